/* src/pov_params.svh */
`ifndef POV_PARAMS_SVH
`define POV_PARAMS_SVH

// Number of LED driver outputs, one serial bit each per step
`define POV_DRIVERS 4
// LEDs chained behind each driver within one column
`define POV_LEDS 4
// Columns multiplexed through the same drivers in one slice
`define POV_COLUMNS 2
// Slices that the host can hold in the slice RAM
`define POV_SLICES 2
// Poker width of the driver, the low bits beyond the color are zero
`define POV_POKER_BITS 7
// Intensity bits of one color in an RGB555 voxel
`define POV_COLOR_BITS 5

// Words in one column buffer, one voxel per LED of every driver
`define POV_COL_WORDS (`POV_DRIVERS * `POV_LEDS)
`define POV_SLICE_WORDS (`POV_COL_WORDS * `POV_COLUMNS)
`define POV_RAM_WORDS (`POV_SLICE_WORDS * `POV_SLICES)
`define POV_ADDR_BITS 6

`endif

/* src/pov_pixel_pkg.sv */
`include "pov_params.svh"

package pov_pixel_pkg;

    // Intensity of one color channel
    typedef logic [`POV_COLOR_BITS-1:0] color_t;

    // Voxel as the host packs it, the top bit is unused
    typedef struct packed {
        logic   pad;
        color_t red;
        color_t green;
        color_t blue;
    } rgb555_t;

    // One RAM word, seen raw by the bus and as colors by the stream side
    typedef union packed {
        logic [3*`POV_COLOR_BITS:0] raw;
        rgb555_t                    rgb;
    } ram_word_u;

    // Color being streamed, the encoding order is also the send order
    typedef enum logic [1:0] {
        sel_blue,
        sel_green,
        sel_red
    } color_sel_t;

endpackage

/* src/pov_ctrl_pkg.sv */
`include "pov_params.svh"

package pov_ctrl_pkg;

    // Sequencer states for one slice
    typedef enum logic [2:0] {
        idle,
        wait_sync,
        fill_first,
        stream,
        swap_wait
    } stream_state_t;

    // Scan position indices, sized from the geometry
    typedef logic [$clog2(`POV_LEDS)-1:0] led_idx_t;
    typedef logic [$clog2(`POV_POKER_BITS)-1:0] bit_idx_t;
    typedef logic [$clog2(`POV_COLUMNS)-1:0] col_idx_t;

    // Slice currently selected in the RAM
    typedef logic [$clog2(`POV_SLICES)-1:0] slice_idx_t;

endpackage

/* src/scan_if.sv */
`include "pov_params.svh"

// Scan position shared by the counter, the sequencer and the data path
interface scan_if;
    import pov_pixel_pkg::*;
    import pov_ctrl_pkg::*;

    color_sel_t color;
    led_idx_t   led;
    bit_idx_t   poker_bit;
    col_idx_t   column;
    // High in every cycle where one bit per driver is sent
    logic       step;
    // Qualified with step, so they only mark the final step
    logic       column_done;
    logic       slice_done;

    modport counter (output color, led, poker_bit, column, step, column_done, slice_done);
    modport fsm (input column_done, slice_done);
    modport reader (input color, led, poker_bit, column);
endinterface

// Column fill requests and the RAM read port behind them
interface fill_if;
    import pov_pixel_pkg::*;
    import pov_ctrl_pkg::*;

    logic                     fill_start;
    col_idx_t                 fill_column;
    slice_idx_t               fill_slice;
    logic                     fill_busy;
    // Buffer being streamed, the filler always writes the other one
    logic                     buffer_sel;
    logic [`POV_ADDR_BITS-1:0] rd_addr;
    ram_word_u                rd_data;

    modport fsm (output fill_start, fill_column, fill_slice, buffer_sel, input fill_busy);
    modport filler (input fill_start, fill_column, fill_slice, buffer_sel, rd_data,
                    output fill_busy, rd_addr);
    modport ram (input rd_addr, output rd_data);
endinterface

/* src/slice_ram_apb.sv */
`include "pov_params.svh"

module slice_ram_apb (
    input  logic        clk,
    input  logic        nrst,
    input  logic [15:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    fill_if.ram         fill
);
    import pov_pixel_pkg::*;

    localparam int addr_w = `POV_ADDR_BITS;

    // Voxel storage, slices back to back
    ram_word_u mem [`POV_RAM_WORDS];

    logic              in_range;
    logic              setup_phase;
    logic              write_commit;
    logic [addr_w-1:0] word_idx;

    // Word addressing, anything past the last voxel is an error
    assign in_range = paddr < 16'(`POV_RAM_WORDS);
    assign word_idx = paddr[addr_w-1:0];
    assign setup_phase = psel && !penable;
    assign write_commit = psel && penable && pwrite && in_range;

    // The RAM never stalls the bus
    assign pready = 1'b1;

    // The error flag is computed in the setup phase and shown during the access phase
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup_phase && !in_range;
        end
    end

    // Host port with bus writes committed in the access phase
    always_ff @(posedge clk) begin
        if (write_commit) begin
            mem[word_idx].raw <= pwdata;
        end
        // Read data is fetched in the setup phase so it is stable during access
        if (setup_phase) begin
            prdata <= in_range ? mem[word_idx].raw : '0;
        end
    end

    // Column filler port, one cycle of latency from address to data
    always_ff @(posedge clk) begin
        fill.rd_data <= mem[fill.rd_addr];
    end

endmodule

/* src/column_fill.sv */
`include "pov_params.svh"

module column_fill (
    input  logic                                      clk,
    input  logic                                      nrst,
    fill_if.filler                                    fill,
    scan_if.reader                                    scan,
    output pov_pixel_pkg::ram_word_u [`POV_DRIVERS-1:0] word
);
    import pov_pixel_pkg::*;

    localparam int addr_w = `POV_ADDR_BITS;
    localparam int idx_w = $clog2(`POV_COL_WORDS);
    localparam logic [addr_w-1:0] slice_words = `POV_SLICE_WORDS;
    localparam logic [addr_w-1:0] col_words = `POV_COL_WORDS;

    // Ping-pong pair, one streams while the other is written
    ram_word_u col_buf [2][`POV_COL_WORDS];

    logic [addr_w-1:0] base_addr;
    logic [idx_w-1:0]  rd_idx;
    logic [idx_w-1:0]  wr_idx;
    logic              wr_pending;
    logic              target;

    assign fill.rd_addr = base_addr + addr_w'(rd_idx);

    // Read sequencer, issues one address per cycle while busy
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fill.fill_busy <= 1'b0;
            rd_idx <= '0;
            wr_pending <= 1'b0;
        end else begin
            // The word for the address issued now arrives next cycle
            wr_pending <= fill.fill_busy;
            if (fill.fill_start) begin
                fill.fill_busy <= 1'b1;
                rd_idx <= '0;
            end else if (fill.fill_busy) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == idx_w'(`POV_COL_WORDS - 1)) begin
                    fill.fill_busy <= 1'b0;
                end
            end
        end
    end

    // Capture the request and write each returned word into the idle buffer
    always_ff @(posedge clk) begin
        wr_idx <= rd_idx;
        if (fill.fill_start) begin
            base_addr <= addr_w'(fill.fill_slice) * slice_words
                       + addr_w'(fill.fill_column) * col_words;
            target <= !fill.buffer_sel;
        end
        if (wr_pending) begin
            col_buf[target][wr_idx] <= fill.rd_data;
        end
    end

    // Each driver sees its own voxel of the current LED in the active buffer
    always_comb begin
        for (int d = 0; d < `POV_DRIVERS; d++) begin
            word[d] = col_buf[fill.buffer_sel][idx_w'(d * `POV_LEDS) + idx_w'(scan.led)];
        end
    end

endmodule

/* src/scan_counter.sv */
`include "pov_params.svh"

module scan_counter (
    input  logic     clk,
    input  logic     nrst,
    input  logic     enable,
    input  logic     driver_ready,
    input  logic     restart,
    scan_if.counter  scan
);
    import pov_pixel_pkg::*;
    import pov_ctrl_pkg::*;

    logic last_of_column;

    // A restart wins over a step so no stale bit leaves during an abort
    assign scan.step = enable && driver_ready && !restart;

    // Last color of the last LED at the lowest poker bit
    assign last_of_column = scan.color == sel_red && scan.led == '0 && scan.poker_bit == '0;
    assign scan.column_done = scan.step && last_of_column;
    assign scan.slice_done = scan.column_done
                           && scan.column == col_idx_t'(`POV_COLUMNS - 1);

    // Poker order nesting, from the outside in: bit, LED, color
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scan.color <= sel_blue;
            scan.led <= led_idx_t'(`POV_LEDS - 1);
            scan.poker_bit <= bit_idx_t'(`POV_POKER_BITS - 1);
            scan.column <= '0;
        end else if (restart) begin
            scan.color <= sel_blue;
            scan.led <= led_idx_t'(`POV_LEDS - 1);
            scan.poker_bit <= bit_idx_t'(`POV_POKER_BITS - 1);
            scan.column <= '0;
        end else if (scan.step) begin
            if (scan.color != sel_red) begin
                scan.color <= color_sel_t'(scan.color + 1'b1);
            end else begin
                // All three colors of this LED are out
                scan.color <= sel_blue;
                if (scan.led != '0) begin
                    scan.led <= scan.led - 1'b1;
                end else begin
                    // Every LED has this bit, move to the next lower one
                    scan.led <= led_idx_t'(`POV_LEDS - 1);
                    if (scan.poker_bit != '0) begin
                        scan.poker_bit <= scan.poker_bit - 1'b1;
                    end else begin
                        scan.poker_bit <= bit_idx_t'(`POV_POKER_BITS - 1);
                        // Column complete, the last one wraps for the next slice
                        if (scan.column == col_idx_t'(`POV_COLUMNS - 1)) begin
                            scan.column <= '0;
                        end else begin
                            scan.column <= scan.column + 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

/* src/stream_fsm.sv */
`include "pov_params.svh"

module stream_fsm (
    input  logic clk,
    input  logic nrst,
    input  logic stream_ready,
    input  logic position_sync,
    scan_if.fsm  scan,
    fill_if.fsm  fill,
    output logic enable,
    output logic restart
);
    import pov_ctrl_pkg::*;

    stream_state_t state;
    slice_idx_t    slice_idx;
    logic          fill_pending;
    logic          last_fill;
    logic          swap;

    // A fill counts as running from the request pulse on
    assign fill_pending = fill.fill_start || fill.fill_busy;
    assign last_fill = fill.fill_column == col_idx_t'(`POV_COLUMNS - 1);
    assign fill.fill_slice = slice_idx;

    assign enable = state == stream;
    // Counters sit at the first step whenever no slice is under way
    assign restart = !stream_ready || state == idle || state == wait_sync;

    // The buffers swap once the fill is complete and a column boundary is reached
    assign swap = stream_ready && !fill_pending
                && (state == fill_first || state == swap_wait
                    || (state == stream && scan.column_done && !scan.slice_done));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= idle;
            slice_idx <= '0;
            fill.fill_start <= 1'b0;
            fill.fill_column <= '0;
            fill.buffer_sel <= 1'b0;
        end else begin
            fill.fill_start <= 1'b0;
            // Swap to the filled buffer and start the next column behind it
            if (swap) begin
                fill.buffer_sel <= !fill.buffer_sel;
                if (!last_fill) begin
                    fill.fill_start <= 1'b1;
                    fill.fill_column <= fill.fill_column + 1'b1;
                end
            end
            if (!stream_ready) begin
                state <= idle;
            end else begin
                case (state)
                    idle: state <= wait_sync;
                    wait_sync: begin
                        if (position_sync) begin
                            state <= fill_first;
                            fill.fill_start <= 1'b1;
                            fill.fill_column <= '0;
                        end
                    end
                    fill_first: if (swap) state <= stream;
                    stream: begin
                        if (scan.slice_done) begin
                            state <= wait_sync;
                            // Step to the next slice in RAM with a wrap at the end
                            if (slice_idx == slice_idx_t'(`POV_SLICES - 1)) begin
                                slice_idx <= '0;
                            end else begin
                                slice_idx <= slice_idx + 1'b1;
                            end
                        end else if (scan.column_done && fill_pending) begin
                            state <= swap_wait;
                        end
                    end
                    swap_wait: if (swap) state <= stream;
                    default: state <= idle;
                endcase
            end
        end
    end

endmodule

/* src/bit_serializer.sv */
`include "pov_params.svh"

module bit_serializer (
    input  logic                                     clk,
    input  logic                                     nrst,
    input  logic                                     step,
    scan_if.reader                                   scan,
    input  pov_pixel_pkg::ram_word_u [`POV_DRIVERS-1:0] word,
    output logic [`POV_DRIVERS-1:0]                  data,
    output logic                                     data_valid
);
    import pov_pixel_pkg::*;
    import pov_ctrl_pkg::*;

    // Poker bits below the color width are sent as zero
    localparam bit_idx_t pad_bits = bit_idx_t'(`POV_POKER_BITS - `POV_COLOR_BITS);

    bit_idx_t                 bit_pos;
    color_t [`POV_DRIVERS-1:0] color_val;
    logic [`POV_DRIVERS-1:0]   next_data;

    // Color bit behind the current poker bit, MSB aligned
    assign bit_pos = scan.poker_bit - pad_bits;

    always_comb begin
        for (int d = 0; d < `POV_DRIVERS; d++) begin
            // Decode the voxel and pick the color being sent
            case (scan.color)
                sel_red:   color_val[d] = word[d].rgb.red;
                sel_green: color_val[d] = word[d].rgb.green;
                default:   color_val[d] = word[d].rgb.blue;
            endcase
            next_data[d] = scan.poker_bit >= pad_bits ? color_val[d][bit_pos] : 1'b0;
        end
    end

    // Valid marks exactly the cycles that follow a step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= step;
        end
    end

    always_ff @(posedge clk) begin
        data <= next_data;
    end

endmodule

/* src/pov_framebuffer_top.sv */
`include "pov_params.svh"

module pov_framebuffer_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic [15:0]             paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [15:0]             pwdata,
    output logic [15:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    stream_ready,
    input  logic                    driver_ready,
    input  logic                    position_sync,
    output logic [`POV_DRIVERS-1:0] data,
    output logic                    data_valid
);
    import pov_pixel_pkg::*;

    logic                         enable;
    logic                         restart;
    // Active buffer voxel for each driver at the current LED
    ram_word_u [`POV_DRIVERS-1:0] word;

    scan_if scan ();
    fill_if fill ();

    // Host side storage and the read port for column fills
    slice_ram_apb u_ram (
        .clk     (clk),
        .nrst    (nrst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .fill    (fill.ram)
    );

    column_fill u_fill (
        .clk  (clk),
        .nrst (nrst),
        .fill (fill.filler),
        .scan (scan.reader),
        .word (word)
    );

    scan_counter u_counter (
        .clk          (clk),
        .nrst         (nrst),
        .enable       (enable),
        .driver_ready (driver_ready),
        .restart      (restart),
        .scan         (scan.counter)
    );

    stream_fsm u_fsm (
        .clk           (clk),
        .nrst          (nrst),
        .stream_ready  (stream_ready),
        .position_sync (position_sync),
        .scan          (scan.fsm),
        .fill          (fill.fsm),
        .enable        (enable),
        .restart       (restart)
    );

    // Driver side output stage
    bit_serializer u_serializer (
        .clk        (clk),
        .nrst       (nrst),
        .step       (scan.step),
        .scan       (scan.reader),
        .word       (word),
        .data       (data),
        .data_valid (data_valid)
    );

endmodule

/* tests/pov_framebuffer_tb.sv */
`include "pov_params.svh"

module pov_framebuffer_tb;

    // A column has three color steps for every LED at every poker bit
    localparam int col_steps = `POV_POKER_BITS * `POV_LEDS * 3;
    localparam int slice_steps = col_steps * `POV_COLUMNS;
    localparam int pad_bits = `POV_POKER_BITS - `POV_COLOR_BITS;
    localparam int addr_w = `POV_ADDR_BITS;
    // Characters the command reader cares about
    localparam int ch_tab = 9;
    localparam int ch_nl = 10;
    localparam int ch_cr = 13;
    localparam int ch_sp = 32;
    localparam int ch_hash = 35;

    logic                    clk;
    logic                    nrst;
    logic [15:0]             paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [15:0]             pwdata;
    logic [15:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    stream_ready;
    logic                    driver_ready;
    logic                    position_sync;
    logic [`POV_DRIVERS-1:0] data;
    logic                    data_valid;

    // Host view of the slice RAM that follows every bus write
    logic [15:0] model_mem [`POV_RAM_WORDS];

    // Commands from the test file with one entry per line
    logic [7:0]  cmd_q [$];
    logic [15:0] arg0_q [$];
    logic [15:0] arg1_q [$];

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    // Slice that the DUT should stream on the next sync
    int tb_slice = 0;
    // Percentage of cycles with driver_ready high during the next stream
    int duty = 100;

    pov_framebuffer_top UUT (
        .clk           (clk),
        .nrst          (nrst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .stream_ready  (stream_ready),
        .driver_ready  (driver_ready),
        .position_sync (position_sync),
        .data          (data),
        .data_valid    (data_valid)
    );

    always #4 clk = ~clk;

    // The watchdog limit scales with the number of commands
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped producing output", cycle_count);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [15:0] got,
                                   input logic [15:0] want);
        errors++;
        $display("Error at %0t: %s, got %h, expected %h", $time, what, got, want);
    endtask

    // Expected bits walk the column, then the poker bit, the LED and blue, green, red
    function automatic logic [`POV_DRIVERS-1:0] expected_data(input int slice, input int k);
        int                      col;
        int                      rest;
        int                      pbit;
        int                      led;
        int                      addr;
        logic [15:0]             voxel;
        logic [4:0]              val;
        logic [`POV_DRIVERS-1:0] bits;
        col = k / col_steps;
        rest = k % col_steps;
        pbit = `POV_POKER_BITS - 1 - rest / (`POV_LEDS * 3);
        rest = rest % (`POV_LEDS * 3);
        led = `POV_LEDS - 1 - rest / 3;
        for (int d = 0; d < `POV_DRIVERS; d++) begin
            addr = slice * `POV_SLICE_WORDS + col * `POV_COL_WORDS + d * `POV_LEDS + led;
            voxel = model_mem[addr_w'(addr)];
            // Blue sits in the low bits and red right under the unused top bit
            case (rest % 3)
                0: val = voxel[4:0];
                1: val = voxel[9:5];
                default: val = voxel[14:10];
            endcase
            bits[d] = pbit >= pad_bits ? val[3'(pbit - pad_bits)] : 1'b0;
        end
        return bits;
    endfunction

    // One APB transfer whose status and read data are taken in the access phase
    task automatic apb_transfer(input logic wr, input logic [15:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic err, output logic rdy);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        rdata = prdata;
        err = pslverr;
        rdy = pready;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic pulse_sync();
        @(posedge clk);
        #1;
        position_sync = 1'b1;
        @(posedge clk);
        #1;
        position_sync = 1'b0;
    endtask

    // Nothing may leave the DUT while no slice is under way
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            checks++;
            if (data_valid !== 1'b0) begin
                report_mismatch("data_valid outside a slice", 16'(data_valid), 16'h0);
            end
        end
    endtask

    // Compare each valid output with the model until count outputs were seen
    task automatic collect_stream(input int count, input int slice, input int ready_pct);
        int                      seen;
        logic [`POV_DRIVERS-1:0] want;
        seen = 0;
        while (seen < count) begin
            @(posedge clk);
            #1;
            if (data_valid === 1'b1) begin
                want = expected_data(slice, seen);
                checks++;
                if (data !== want) begin
                    report_mismatch($sformatf("slice %0d step %0d", slice, seen),
                                    16'(data), 16'(want));
                end
                seen++;
            end
            if (ready_pct < 100) begin
                driver_ready = ($urandom % 100) < ready_pct;
            end
        end
        driver_ready = 1'b1;
    endtask

    // Start a slice and pull stream_ready away part way through it
    task automatic abort_slice(input int outputs, input int slice);
        pulse_sync();
        collect_stream(outputs, slice, 100);
        stream_ready = 1'b0;
        expect_quiet(4);
        stream_ready = 1'b1;
        expect_quiet(2);
    endtask

    task automatic load_commands(output bit ok);
        int          fd;
        int          c;
        int          n;
        logic [15:0] a0;
        logic [15:0] a1;
        ok = 1'b0;
        fd = $fopen("tests/pov_framebuffer_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == ch_hash) begin
                    // A comment runs to the end of its line
                    while (c != -1 && c != ch_nl) begin
                        c = $fgetc(fd);
                    end
                end else if (c != ch_sp && c != ch_nl && c != ch_cr && c != ch_tab) begin
                    n = $fscanf(fd, " %h %h", a0, a1);
                    if (n == 2) begin
                        cmd_q.push_back(8'(c));
                        arg0_q.push_back(a0);
                        arg1_q.push_back(a1);
                    end else begin
                        $display("Malformed line in the test file after command %0d",
                                 cmd_q.size());
                        ok = 1'b0;
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic preload_ram();
        logic [15:0] word;
        logic [15:0] rdata;
        logic        err;
        logic        rdy;
        for (int a = 0; a < `POV_RAM_WORDS; a++) begin
            // Odd multiplier so that every address bit changes the word
            word = 16'(a * 3381 + 4660);
            apb_transfer(1'b1, 16'(a), word, rdata, err, rdy);
            model_mem[addr_w'(a)] = word;
        end
    endtask

    task automatic run_command(input int i);
        logic [15:0] rdata;
        logic        err;
        logic        rdy;
        case (cmd_q[i])
            "W": begin
                apb_transfer(1'b1, arg0_q[i], arg1_q[i], rdata, err, rdy);
                model_mem[arg0_q[i][addr_w-1:0]] = arg1_q[i];
                checks++;
                if (err !== 1'b0 || rdy !== 1'b1) begin
                    report_mismatch("write status {pslverr, pready}", 16'({err, rdy}), 16'h1);
                end
            end
            "R": begin
                apb_transfer(1'b0, arg0_q[i], 16'h0, rdata, err, rdy);
                checks++;
                if (rdata !== arg1_q[i]) begin
                    report_mismatch($sformatf("read of %h", arg0_q[i]), rdata, arg1_q[i]);
                end
                checks++;
                if (err !== 1'b0 || rdy !== 1'b1) begin
                    report_mismatch("read status {pslverr, pready}", 16'({err, rdy}), 16'h1);
                end
            end
            "X": begin
                // An out of range write leaves the model as it is
                apb_transfer(1'b1, arg0_q[i], arg1_q[i], rdata, err, rdy);
                checks++;
                if (err !== 1'b1 || rdy !== 1'b1) begin
                    report_mismatch($sformatf("status {pslverr, pready} at %h", arg0_q[i]),
                                    16'({err, rdy}), 16'h3);
                end
            end
            "S": begin
                pulse_sync();
                collect_stream(slice_steps, tb_slice, duty);
                expect_quiet(4);
                tb_slice = (tb_slice + 1) % `POV_SLICES;
                duty = 100;
            end
            "B": duty = int'(arg0_q[i]);
            "A": abort_slice(int'(arg0_q[i]), tb_slice);
            default: begin
                errors++;
                $display("Unknown command code %h in the test file", cmd_q[i]);
            end
        endcase
    endtask

    initial begin
        bit loaded;
        clk = 1'b0;
        nrst = 1'b0;
        paddr = 16'h0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 16'h0;
        stream_ready = 1'b1;
        driver_ready = 1'b1;
        position_sync = 1'b0;
        void'($urandom(32'h94fb));
        load_commands(loaded);
        if (!loaded) begin
            $display("Could not read the command file tests/pov_framebuffer_tests.txt");
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end else begin
            // One extra share of cycles covers reset and the RAM preload
            cycle_limit = (cmd_q.size() + 1) * 1000;
            repeat (5) @(posedge clk);
            #1;
            nrst = 1'b1;
            checks++;
            if (pslverr !== 1'b0) begin
                report_mismatch("pslverr after reset", 16'(pslverr), 16'h0);
            end
            // Streaming is allowed but no sync has arrived yet
            expect_quiet(20);
            preload_ram();
            for (int i = 0; i < cmd_q.size(); i++) begin
                run_command(i);
            end
            $display("Checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* tests/pov_framebuffer_tests.txt */
# Columns: command, arg0, arg1, all numbers in hex, unused fields are 0
# W addr data | R addr expected | X addr data | S 0 0 | B ready_percent 0 | A outputs 0
W 0000 7fff
W 0011 0421
W 0025 8000
W 003f 2a55
R 0000 7fff
R 0011 0421
R 0025 8000
X 0040 1234
X 1000 5555
R 0000 7fff  # aliased out of range writes must not land
S 0 0        # slice 0
S 0 0        # slice 1
S 0 0        # slice 0 again
B 28 0
S 0 0        # slice 1 with driver_ready at 40 percent
A 64 0       # slice 0 cut in its second column
S 0 0        # slice 0 from its first step
A e 0        # slice 1 cut while the second column fills
B 32 0
S 0 0        # slice 1 with driver_ready at 50 percent
R 003f 2a55

/* pov_framebuffer_top.f */
+incdir+src
src/pov_pixel_pkg.sv
src/pov_ctrl_pkg.sv
src/scan_if.sv
src/slice_ram_apb.sv
src/column_fill.sv
src/scan_counter.sv
src/stream_fsm.sv
src/bit_serializer.sv
src/pov_framebuffer_top.sv
tests/pov_framebuffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module pov_framebuffer_tb -f pov_framebuffer_top.f -o pov_sim &&
./obj_dir/pov_sim | tee /dev/stderr | grep -qx "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
